// ==== hba_pkg.sv ====
package hba_pkg;

    // bus widths
    typedef logic [7:0] byte_t;         // serial byte, bus data word
    typedef logic [3:0] periph_addr_t;  // peripheral slot number
    typedef logic [7:0] reg_addr_t;     // register inside a slot

    // slot map, slot 0 is the serial host itself
    localparam periph_addr_t SLOT_BASICIO = 4'd1;
    localparam periph_addr_t SLOT_GPIO    = 4'd2;

    // command byte: bit 7 write flag, bits 3..0 slot
    localparam int CMD_WRITE_BIT = 7;
    localparam int CMD_SLOT_MSB  = 3;

    // basicio registers
    localparam reg_addr_t BASICIO_REG_LED    = 8'd0;
    localparam reg_addr_t BASICIO_REG_BUTTON = 8'd1;

    // gpio registers
    localparam reg_addr_t GPIO_REG_OUT_EN  = 8'd0;
    localparam reg_addr_t GPIO_REG_OUT_SIG = 8'd1;
    localparam reg_addr_t GPIO_REG_IN_SIG  = 8'd2;

    // command parser states
    typedef enum logic [1:0] {
        PS_CMD,   // waiting for command byte
        PS_REG,   // waiting for register byte
        PS_DATA   // waiting for write data
    } parse_state_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx import hba_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  rxd,
    output byte_t rx_data,
    output logic  rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic             rxd_meta;   // first sync flop
    logic             rxd_sync;   // safe to use
    logic [CNT_W-1:0] clk_cnt;    // cycles inside the current bit
    logic [2:0]       bit_idx;    // data bit being received
    byte_t            shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;     // line idles high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rxd_sync) state <= RX_START;  // falling edge of start bit
                end
                RX_START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        // glitch if line went back high before mid start bit
                        state <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin  // middle of data bit
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin  // RX_STOP
                    if (clk_cnt == FULL_BIT) begin
                        rx_valid <= rxd_sync;  // drop the byte on a bad stop bit
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == FULL_BIT) shift <= {rxd_sync, shift[7:1]};
    end

    assign rx_data = shift;

endmodule

// ==== cmd_parser.sv ====
`timescale 1ns/10ps

module cmd_parser import hba_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  byte_t        rx_data,
    input  logic         rx_valid,
    output logic         bus_en,
    output logic         bus_wr,
    output periph_addr_t bus_periph,
    output reg_addr_t    bus_reg,
    output byte_t        bus_wdata,
    output byte_t        rd_data
);

    parse_state_t state;

    // fsm plus bus strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= PS_CMD;
            bus_en <= 1'b0;
            bus_wr <= 1'b0;
        end else begin
            bus_en <= 1'b0;   // single cycle pulse
            if (rx_valid) begin
                case (state)
                    PS_CMD: begin
                        bus_wr <= rx_data[CMD_WRITE_BIT];
                        state  <= PS_REG;
                    end
                    PS_REG: begin
                        if (bus_wr) begin
                            state <= PS_DATA;   // write needs one more byte
                        end else begin
                            bus_en <= 1'b1;     // read is complete
                            state  <= PS_CMD;
                        end
                    end
                    default: begin  // PS_DATA
                        bus_en <= 1'b1;
                        state  <= PS_CMD;
                    end
                endcase
            end
        end
    end

    // address and data capture
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                PS_CMD:  bus_periph <= rx_data[CMD_SLOT_MSB:0];
                PS_REG:  bus_reg    <= rx_data;
                default: bus_wdata  <= rx_data;
            endcase
        end
    end

    // read data starts empty, each slot fills in its own
    assign rd_data = 8'h00;

endmodule

// ==== hba_basicio.sv ====
`timescale 1ns/10ps

module hba_basicio import hba_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         bus_en,
    input  logic         bus_wr,
    input  periph_addr_t bus_periph,
    input  reg_addr_t    bus_reg,
    input  byte_t        bus_wdata,
    input  byte_t        rd_data,
    output logic         bus_en_r,
    output logic         bus_wr_r,
    output periph_addr_t bus_periph_r,
    output reg_addr_t    bus_reg_r,
    output byte_t        bus_wdata_r,
    output logic         rd_valid_r,
    output byte_t        rd_data_r,
    output byte_t        basicio_led,
    input  logic [1:0]   basicio_button,
    output logic         intr
);

    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic [1:0] btn_last;     // for change detect
    logic       sel;          // transaction hits this slot
    logic       rd_hit;
    byte_t      rd_value;

    assign sel    = bus_en && (bus_periph == SLOT_BASICIO);
    assign rd_hit = sel && !bus_wr;

    always_comb begin
        case (bus_reg)
            BASICIO_REG_LED:    rd_value = basicio_led;
            BASICIO_REG_BUTTON: rd_value = {6'b0, btn_sync};
            default:            rd_value = 8'h00;   // unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            basicio_led <= 8'h00;
            btn_meta    <= 2'b00;
            btn_sync    <= 2'b00;
            btn_last    <= 2'b00;
            intr        <= 1'b0;
            bus_en_r    <= 1'b0;
            rd_valid_r  <= 1'b0;
        end else begin
            btn_meta <= basicio_button;
            btn_sync <= btn_meta;
            btn_last <= btn_sync;
            if (sel && bus_wr && bus_reg == BASICIO_REG_LED) basicio_led <= bus_wdata;
            if (btn_sync != btn_last) intr <= 1'b1;   // a new change wins over the clear
            else if (rd_hit && bus_reg == BASICIO_REG_BUTTON) intr <= 1'b0;
            bus_en_r   <= bus_en;
            rd_valid_r <= bus_en && !bus_wr;          // any slot
        end
    end

    // bus forwarded one stage on
    always_ff @(posedge clk) begin
        bus_wr_r     <= bus_wr;
        bus_periph_r <= bus_periph;
        bus_reg_r    <= bus_reg;
        bus_wdata_r  <= bus_wdata;
        rd_data_r    <= rd_hit ? rd_value : rd_data;
    end

endmodule

// ==== hba_gpio.sv ====
`timescale 1ns/10ps

module hba_gpio import hba_pkg::*; #(
    parameter int GPIO_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bus_en,
    input  logic                  bus_wr,
    input  periph_addr_t          bus_periph,
    input  reg_addr_t             bus_reg,
    input  byte_t                 bus_wdata,
    input  logic                  rd_valid,
    input  byte_t                 rd_data,
    output logic                  resp_valid,
    output byte_t                 resp_data,
    output logic [GPIO_WIDTH-1:0] gpio_out_en,
    output logic [GPIO_WIDTH-1:0] gpio_out_sig,
    input  logic [GPIO_WIDTH-1:0] gpio_in_sig
);

    logic [GPIO_WIDTH-1:0] in_meta;
    logic [GPIO_WIDTH-1:0] in_sync;   // pins after two flops
    logic                  sel;
    logic                  wr_hit;
    byte_t                 rd_value;

    assign sel    = bus_en && (bus_periph == SLOT_GPIO);
    assign wr_hit = sel && bus_wr;

    // narrow registers read back zero extended
    always_comb begin
        rd_value = 8'h00;
        case (bus_reg)
            GPIO_REG_OUT_EN:  rd_value[GPIO_WIDTH-1:0] = gpio_out_en;
            GPIO_REG_OUT_SIG: rd_value[GPIO_WIDTH-1:0] = gpio_out_sig;
            GPIO_REG_IN_SIG:  rd_value[GPIO_WIDTH-1:0] = in_sync;
            default:          rd_value = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        in_meta <= gpio_in_sig;
        in_sync <= in_meta;
        resp_data <= (sel && !bus_wr) ? rd_value : rd_data;  // last stage picks its own
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_out_en  <= '0;    // pins start as inputs
            gpio_out_sig <= '0;
            resp_valid   <= 1'b0;
        end else begin
            if (wr_hit && bus_reg == GPIO_REG_OUT_EN)  gpio_out_en  <= bus_wdata[GPIO_WIDTH-1:0];
            if (wr_hit && bus_reg == GPIO_REG_OUT_SIG) gpio_out_sig <= bus_wdata[GPIO_WIDTH-1:0];
            resp_valid <= rd_valid;   // bus ends here, only the response goes on
        end
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx import hba_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic  clk,
    input  logic  reset,
    input  byte_t resp_data,
    input  logic  resp_valid,
    output logic  txd
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    logic             busy;
    logic [CNT_W-1:0] clk_cnt;   // cycles inside the current bit
    logic [3:0]       bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic [8:0]       shift;     // data bits then stop bit

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            txd     <= 1'b1;    // idle high
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            if (resp_valid) begin
                busy <= 1'b1;
                txd  <= 1'b0;   // start bit next cycle
            end
        end else if (clk_cnt == FULL_BIT) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;   // stop bit done, txd already high
            end else begin
                txd     <= shift[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // frame payload, shifted lsb first with ones behind
    always_ff @(posedge clk) begin
        if (!busy && resp_valid) begin
            shift <= {1'b1, resp_data};
        end else if (busy && clk_cnt == FULL_BIT) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

// ==== hba_system.sv ====
`timescale 1ns/10ps

module hba_system import hba_pkg::*; #(
    parameter int CLK_FREQUENCY = 1_000_000,
    parameter int BAUD          = 125_000,
    parameter int GPIO_WIDTH    = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rxd,
    output logic                  txd,
    output logic                  intr,
    output byte_t                 basicio_led,
    input  logic [1:0]            basicio_button,
    output logic [GPIO_WIDTH-1:0] gpio_out_en,
    output logic [GPIO_WIDTH-1:0] gpio_out_sig,
    input  logic [GPIO_WIDTH-1:0] gpio_in_sig
);

    localparam int CLKS_PER_BIT = CLK_FREQUENCY / BAUD;

    // serial receive to parser
    byte_t        rx_data;
    logic         rx_valid;
    // parser to basicio
    logic         bus_en;
    logic         bus_wr;
    periph_addr_t bus_periph;
    reg_addr_t    bus_reg;
    byte_t        bus_wdata;
    byte_t        rd_data;
    // basicio to gpio
    logic         b1_bus_en;
    logic         b1_bus_wr;
    periph_addr_t b1_bus_periph;
    reg_addr_t    b1_bus_reg;
    byte_t        b1_bus_wdata;
    logic         b1_rd_valid;
    byte_t        b1_rd_data;
    // gpio to serial transmit
    logic         resp_valid;
    byte_t        resp_data;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
        .clk, .reset, .rxd, .rx_data, .rx_valid
    );

    cmd_parser i_cmd_parser (
        .clk, .reset, .rx_data, .rx_valid,
        .bus_en, .bus_wr, .bus_periph, .bus_reg, .bus_wdata, .rd_data
    );

    hba_basicio i_hba_basicio (
        .clk, .reset,
        .bus_en, .bus_wr, .bus_periph, .bus_reg, .bus_wdata, .rd_data,
        .bus_en_r(b1_bus_en), .bus_wr_r(b1_bus_wr), .bus_periph_r(b1_bus_periph),
        .bus_reg_r(b1_bus_reg), .bus_wdata_r(b1_bus_wdata),
        .rd_valid_r(b1_rd_valid), .rd_data_r(b1_rd_data),
        .basicio_led, .basicio_button, .intr
    );

    hba_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) i_hba_gpio (
        .clk, .reset,
        .bus_en(b1_bus_en), .bus_wr(b1_bus_wr), .bus_periph(b1_bus_periph),
        .bus_reg(b1_bus_reg), .bus_wdata(b1_bus_wdata),
        .rd_valid(b1_rd_valid), .rd_data(b1_rd_data),
        .resp_valid, .resp_data, .gpio_out_en, .gpio_out_sig, .gpio_in_sig
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
        .clk, .reset, .resp_data, .resp_valid, .txd
    );

endmodule

// ==== hba_system_chk.sv ====
`timescale 1ns/10ps

module hba_system_chk (
    input logic clk,
    input logic reset,
    input logic txd,
    input logic rx_valid,
    input logic bus_en,
    input logic resp_valid,
    input logic tx_busy      // uart_tx frame in progress
);

    // idle line is high between frames
    a_txd_idle: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> txd)
        else $error("txd low while the transmitter is idle");

    a_bus_en_pulse: assert property (@(posedge clk) disable iff (reset) bus_en |=> !bus_en)
        else $error("bus_en high two cycles in a row");

    // response always finds the transmitter free
    a_no_backpressure: assert property (@(posedge clk) disable iff (reset) resp_valid |-> !tx_busy)
        else $error("resp_valid while uart_tx is busy");

    a_rx_valid_pulse: assert property (@(posedge clk) disable iff (reset) rx_valid |=> !rx_valid)
        else $error("rx_valid high two cycles in a row");

endmodule

bind hba_system hba_system_chk i_hba_system_chk (
    .clk(clk), .reset(reset), .txd(txd), .rx_valid(rx_valid), .bus_en(bus_en),
    .resp_valid(resp_valid), .tx_busy(i_uart_tx.busy)
);

// ==== tb_hba_system.sv ====
`timescale 1ns/10ps

module tb_hba_system
    import hba_pkg::*;
();

    localparam int GPIO_WIDTH   = 4;
    localparam int CLKS_PER_BIT = 8;    // 1 MHz over 125 kBd
    // 40 commands of at most 40 bit periods each, plus margin
    localparam int MAX_CYCLES   = 40 * 40 * CLKS_PER_BIT + 2000;

    logic                  clk;
    logic                  reset;
    logic                  rxd;
    logic                  txd;
    logic                  intr;
    byte_t                 basicio_led;
    logic [1:0]            basicio_button;
    logic [GPIO_WIDTH-1:0] gpio_out_en;
    logic [GPIO_WIDTH-1:0] gpio_out_sig;
    logic [GPIO_WIDTH-1:0] gpio_in_sig;

    byte_t                 led_m;   // register model
    logic [GPIO_WIDTH-1:0] oe_m;
    logic [GPIO_WIDTH-1:0] out_m;
    logic [31:0]           rng_state;
    int                    cycle_count;
    int                    error_count;
    int                    test_errors;
    int                    tests_passed;
    int                    tests_failed;
    string                 test_name;

    hba_system #(.CLK_FREQUENCY(1_000_000), .BAUD(125_000), .GPIO_WIDTH(GPIO_WIDTH)) i_hba_system (
        .clk, .reset, .rxd, .txd, .intr, .basicio_led, .basicio_button,
        .gpio_out_en, .gpio_out_sig, .gpio_in_sig
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog on the whole run
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles, a test never finished", MAX_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic byte_t rand_byte();
        rng_state = xorshift(rng_state);
        return rng_state[15:8];
    endfunction

    // n rising edges, then 1 ns into the cycle
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic note_error(input string what);
        $display("%s: %s", test_name, what);
        error_count++;
        test_errors++;
    endtask

    task automatic check_value(input string what, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected 0x%02h, actual 0x%02h",
                     test_name, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};   // stop, data, start
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];        // lsb goes first
            step(CLKS_PER_BIT);
        end
    endtask

    task automatic recv_byte(output byte_t b, output bit ok);
        int wait_cycles;
        ok = 1'b0;
        b = 8'h00;
        wait_cycles = 0;
        while (txd === 1'b1 && wait_cycles < 40 * CLKS_PER_BIT) begin
            step(1);
            wait_cycles++;
        end
        if (txd !== 1'b0) begin
            note_error("no start bit seen on txd");
            return;
        end
        step(CLKS_PER_BIT / 2);    // middle of start bit
        if (txd !== 1'b0) begin
            note_error("start bit on txd ended too early");
            return;
        end
        for (int i = 0; i < 8; i++) begin
            step(CLKS_PER_BIT);
            b[i] = txd;
        end
        step(CLKS_PER_BIT);
        if (txd !== 1'b1) begin
            note_error("stop bit on txd is low");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic write_reg(input periph_addr_t slot, input reg_addr_t ra, input byte_t d);
        byte_t cmd;
        bit    quiet;
        cmd = byte_t'(slot);
        cmd[CMD_WRITE_BIT] = 1'b1;
        quiet = 1'b1;
        send_byte(cmd);
        send_byte(ra);
        send_byte(d);
        // ripples through both slots, a write has no response frame
        repeat (2 * CLKS_PER_BIT) begin
            step(1);
            if (txd !== 1'b1) quiet = 1'b0;
        end
        if (!quiet) note_error("txd sent a response to a write");
    endtask

    task automatic read_expect(input string what, input periph_addr_t slot,
                               input reg_addr_t ra, input byte_t expected);
        byte_t got;
        bit    ok;
        send_byte(byte_t'(slot));  // write flag clear
        send_byte(ra);
        recv_byte(got, ok);
        if (ok) check_value(what, expected, got);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic check_outputs();
        check_value("basicio_led", led_m, basicio_led);
        check_value("gpio_out_en", byte_t'(oe_m), byte_t'(gpio_out_en));
        check_value("gpio_out_sig", byte_t'(out_m), byte_t'(gpio_out_sig));
    endtask

    initial begin
        byte_t      d;
        reg_addr_t  ra;
        logic [1:0] btn;
        int         low_seen;
        reset = 1'b1;
        rxd = 1'b1;
        basicio_button = 2'b00;
        gpio_in_sig = '0;
        rng_state = 32'd53;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        led_m = 8'h00;
        oe_m = '0;
        out_m = '0;
        step(2);
        reset = 1'b0;

        start_test("reset");
        check_outputs();
        check_value("intr", 8'h00, byte_t'(intr));
        low_seen = 0;
        repeat (4 * CLKS_PER_BIT) begin
            step(1);
            if (txd !== 1'b1) low_seen++;
        end
        if (low_seen != 0) note_error("txd went low with no command sent");
        finish_test();

        start_test("led");
        repeat (4) begin
            d = rand_byte();
            write_reg(SLOT_BASICIO, BASICIO_REG_LED, d);
            led_m = d;
            check_value("basicio_led", led_m, basicio_led);
            read_expect("led readback", SLOT_BASICIO, BASICIO_REG_LED, led_m);
        end
        finish_test();

        start_test("gpio_out");
        repeat (4) begin
            d = rand_byte();
            ra = {7'b0, d[0]};     // out_en or out_sig
            d = rand_byte();
            write_reg(SLOT_GPIO, ra, d);
            if (ra == GPIO_REG_OUT_EN) oe_m = d[GPIO_WIDTH-1:0];
            else out_m = d[GPIO_WIDTH-1:0];
            check_outputs();
            read_expect("out_en readback", SLOT_GPIO, GPIO_REG_OUT_EN, byte_t'(oe_m));
            read_expect("out_sig readback", SLOT_GPIO, GPIO_REG_OUT_SIG, byte_t'(out_m));
        end
        finish_test();

        start_test("gpio_in");
        repeat (3) begin
            d = rand_byte();
            gpio_in_sig = d[GPIO_WIDTH-1:0];
            step(4);               // two sync flops
            read_expect("gpio_in_sig", SLOT_GPIO, GPIO_REG_IN_SIG, byte_t'(gpio_in_sig));
        end
        finish_test();

        start_test("buttons");
        repeat (2) begin
            d = rand_byte();
            btn = basicio_button ^ ((d[1:0] == 2'b00) ? 2'b01 : d[1:0]);  // always a change
            basicio_button = btn;
            step(5);
            check_value("intr raised", 8'h01, byte_t'(intr));
            read_expect("button readback", SLOT_BASICIO, BASICIO_REG_BUTTON, byte_t'(btn));
            check_value("intr cleared", 8'h00, byte_t'(intr));
        end
        finish_test();

        start_test("unmapped");
        write_reg(4'd5, 8'd0, rand_byte());
        write_reg(SLOT_GPIO, 8'd9, rand_byte());
        write_reg(SLOT_BASICIO, 8'd4, rand_byte());
        check_outputs();           // model unchanged
        read_expect("slot 5", 4'd5, 8'd0, 8'h00);
        read_expect("gpio reg 9", SLOT_GPIO, 8'd9, 8'h00);
        read_expect("basicio reg 4", SLOT_BASICIO, 8'd4, 8'h00);
        finish_test();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hba_pkg.sv
uart_rx.sv
cmd_parser.sv
hba_basicio.sv
hba_gpio.sv
uart_tx.sv
hba_system.sv
hba_system_chk.sv
tb_hba_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_hba_system \
    -f verilog.f -o sim_hba_system \
    && ./obj_dir/sim_hba_system | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null \
    && exit 0 \
    || exit 1
